/* dv/requant_tests.svh */
// expected lane result from a 32-bit sum and its command
function automatic logic [OUT_WIDTH-1:0] expected_lane(input logic [IN_WIDTH-1:0] sum,
                                                       input logic [CMD_WIDTH-1:0] cmd);
    logic [IN_WIDTH-1:0] moved;
    int                  sh;
    if (cmd[CMD_MODE_BIT])
    begin
        sh    = int'(cmd[SHIFT_WIDTH-1:0]) + 1;     // keep bits from s+1 upward
        moved = sum >> sh;
    end
    else
    begin
        moved = sum;                                // bypass keeps the low half
    end
    return moved[OUT_WIDTH-1:0];
endfunction

function automatic logic [ROW_OUT-1:0] expected_row(input logic [ROW_IN-1:0] data);
    logic [ROW_OUT-1:0] r;
    for (int k = 0; k < NUM_LANES; k++)
    begin
        r[k*OUT_WIDTH +: OUT_WIDTH] = expected_lane(data[k*IN_WIDTH +: IN_WIDTH], active_m[k]);
    end
    return r;
endfunction

// drive one row at a falling edge and check it one cycle later
task automatic send_row(input logic en, input logic valid, input logic [ROW_IN-1:0] data);
    logic               exp_valid;
    logic [ROW_OUT-1:0] exp_row;
    exp_valid = en & valid;
    exp_row   = exp_valid ? expected_row(data) : '0;
    i_en      = en;
    i_valid   = valid;
    i_data    = data;
    @(negedge clk);
    check_bit("o_valid", o_valid, exp_valid);
    check_row("o_data", o_data, exp_row);
endtask

task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (o_cfg_ack !== level && n < CFG_TIMEOUT)
    begin
        @(negedge clk);
        n++;
    end
    if (o_cfg_ack !== level)
    begin
        abort_run($sformatf("config ack did not go to %b within %0d cycles", level,
                            CFG_TIMEOUT));
    end
endtask

task automatic cfg_exchange();
    i_en      = 1'b0;                               // no rows during config
    i_valid   = 1'b0;
    i_cfg_req = 1'b1;
    wait_ack(1'b1);
    i_cfg_req = 1'b0;
    wait_ack(1'b0);
endtask

task automatic cfg_write(input logic [LANE_IDX_WIDTH-1:0] lane, input logic [CMD_WIDTH-1:0] cmd);
    i_cfg_lane   = lane;
    i_cfg_cmd    = cmd;
    i_cfg_commit = 1'b0;
    cfg_exchange();
    shadow_m[lane] = cmd;
endtask

task automatic cfg_commit();
    i_cfg_lane   = LANE_IDX_WIDTH'(random_bits(LANE_IDX_WIDTH));   // ignored by a commit
    i_cfg_cmd    = CMD_WIDTH'(random_bits(CMD_WIDTH));
    i_cfg_commit = 1'b1;
    cfg_exchange();
    i_cfg_commit = 1'b0;
    for (int k = 0; k < NUM_LANES; k++)
    begin
        active_m[k] = shadow_m[k];
    end
endtask

task automatic test_bypass_after_reset();
    for (int i = 0; i < 16; i++)
    begin
        send_row(1'b1, 1'b1, random_row());
    end
endtask

task automatic test_all_shifts();
    for (int r = 0; r < 4; r++)
    begin
        for (int k = 0; k < NUM_LANES; k++)
        begin
            cfg_write(LANE_IDX_WIDTH'(k), {1'b1, SHIFT_WIDTH'(4 * k + r)});
        end
        cfg_commit();
        for (int i = 0; i < 4; i++)
        begin
            send_row(1'b1, 1'b1, random_row());
        end
    end
endtask

task automatic test_uncommitted_commands();
    cfg_write(2'd0, 5'b0_0000);
    cfg_write(2'd1, 5'b1_0011);
    cfg_write(2'd2, 5'b0_1010);                     // shift bits set but mode says bypass
    cfg_write(2'd3, 5'b1_1111);
    for (int i = 0; i < 3; i++)
    begin
        send_row(1'b1, 1'b1, random_row());         // still the old bank
    end
    cfg_commit();
    for (int i = 0; i < 3; i++)
    begin
        send_row(1'b1, 1'b1, random_row());
    end
endtask

task automatic test_row_gaps();
    logic en;
    logic valid;
    send_row(1'b1, 1'b1, random_row());
    send_row(1'b0, 1'b1, random_row());
    send_row(1'b1, 1'b1, random_row());
    send_row(1'b1, 1'b0, random_row());
    send_row(1'b0, 1'b0, random_row());
    send_row(1'b1, 1'b1, random_row());
    for (int i = 0; i < 30; i++)
    begin
        en    = next_random_bit();
        valid = next_random_bit() | next_random_bit();
        send_row(en, valid, random_row());
    end
endtask

task automatic test_handshake_and_live_commit();
    check_bit("o_cfg_ack", o_cfg_ack, 1'b0);
    i_cfg_lane   = 2'd2;
    i_cfg_cmd    = 5'b1_0111;
    i_cfg_commit = 1'b0;
    i_cfg_req    = 1'b1;
    send_row(1'b0, 1'b0, random_row());
    check_bit("o_cfg_ack", o_cfg_ack, 1'b1);        // one cycle after req
    for (int i = 0; i < 3; i++)
    begin
        send_row(1'b0, 1'b0, random_row());
        check_bit("o_cfg_ack", o_cfg_ack, 1'b1);    // held with req
    end
    i_cfg_req = 1'b0;
    send_row(1'b0, 1'b0, random_row());
    check_bit("o_cfg_ack", o_cfg_ack, 1'b0);
    shadow_m[2] = 5'b1_0111;

    cfg_write(2'd0, 5'b1_0000);
    cfg_write(2'd1, 5'b0_0000);
    cfg_write(2'd3, 5'b1_1100);

    // commit in the middle of a stream
    for (int i = 0; i < 10; i++)
    begin
        if (i == 4)
        begin
            i_cfg_commit = 1'b1;
            i_cfg_req    = 1'b1;
            for (int k = 0; k < NUM_LANES; k++)
            begin
                active_m[k] = shadow_m[k];  // ack-edge row uses the new bank
            end
        end
        send_row(1'b1, 1'b1, random_row());
        if (i == 4)
        begin
            check_bit("o_cfg_ack", o_cfg_ack, 1'b1);
            i_cfg_req    = 1'b0;
            i_cfg_commit = 1'b0;
        end
        if (i == 5)
        begin
            check_bit("o_cfg_ack", o_cfg_ack, 1'b0);
        end
    end
endtask

/* dv/requant_tb.sv */
`timescale 1ns/100ps

module requant_tb
    import requant_pkg::*;
;

    localparam int CLK_PERIOD   = 100;                  // ns
    localparam int RESET_CYCLES = 4;
    localparam int CFG_TIMEOUT  = 4;                    // cycles allowed for ack to move
    localparam int ROW_IN       = NUM_LANES * IN_WIDTH;
    localparam int ROW_OUT      = NUM_LANES * OUT_WIDTH;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    // upper bounds on the run length over all tests
    localparam int MAX_ROWS        = 100;
    localparam int MAX_XFERS       = 32;
    localparam int XFER_CYCLES     = 2 * (CFG_TIMEOUT + 1);
    localparam int MARGIN_CYCLES   = 50;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_ROWS + MAX_XFERS * XFER_CYCLES
                                     + MARGIN_CYCLES;

    logic                    clk;
    logic                    rst_n;
    logic                    i_en;
    logic                    i_valid;
    logic [ROW_IN-1:0]       i_data;
    logic                    o_valid;
    logic [ROW_OUT-1:0]      o_data;
    logic                    i_cfg_req;
    logic [LANE_IDX_WIDTH-1:0] i_cfg_lane;
    logic [CMD_WIDTH-1:0]    i_cfg_cmd;
    logic                    i_cfg_commit;
    logic                    o_cfg_ack;

    logic [31:0]             lfsr_q;                    // random source state
    logic [CMD_WIDTH-1:0]    shadow_m [NUM_LANES];      // host view of the shadow bank
    logic [CMD_WIDTH-1:0]    active_m [NUM_LANES];      // commands rows are expected to use

    requant_top dut0
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_en         (i_en),
        .i_valid      (i_valid),
        .i_data       (i_data),
        .o_valid      (o_valid),
        .o_data       (o_data),
        .i_cfg_req    (i_cfg_req),
        .i_cfg_lane   (i_cfg_lane),
        .i_cfg_cmd    (i_cfg_cmd),
        .i_cfg_commit (i_cfg_commit),
        .o_cfg_ack    (o_cfg_ack)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_row(input string name, input logic [ROW_OUT-1:0] got,
                             input logic [ROW_OUT-1:0] exp);
        if (got !== exp)
        begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            abort_run($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // galois lfsr stepped once per bit handed out
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = {1'b0, lfsr_q[31:1]} ^ (out_bit ? LFSR_TAPS : 32'h0);
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++)
        begin
            r[b] = next_random_bit();
        end
        return r;
    endfunction

    function automatic logic [ROW_IN-1:0] random_row();
        logic [ROW_IN-1:0] r;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            r[k*IN_WIDTH +: IN_WIDTH] = random_bits(IN_WIDTH);
        end
        return r;
    endfunction

    `include "requant_tests.svh"

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired, the tests did not finish in time");
    end

    initial
    begin
        rst_n        = 1'b0;
        i_en         = 1'b0;
        i_valid      = 1'b0;
        i_data       = '0;
        i_cfg_req    = 1'b0;
        i_cfg_lane   = '0;
        i_cfg_cmd    = '0;
        i_cfg_commit = 1'b0;
        lfsr_q       = 32'h1d2b;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            shadow_m[k] = '0;
            active_m[k] = '0;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        check_bit("o_valid", o_valid, 1'b0);            // still in reset
        check_row("o_data", o_data, '0);
        check_bit("o_cfg_ack", o_cfg_ack, 1'b0);
        rst_n = 1'b1;

        test_bypass_after_reset();
        test_all_shifts();
        test_uncommitted_commands();
        test_row_gaps();
        test_handshake_and_live_commit();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+dv
hdl/requant_pkg.sv
hdl/bit_select_seq.sv
hdl/cmd_regfile.sv
hdl/requant_top.sv
dv/requant_tb.sv

/* hdl/bit_select_seq.sv */
`timescale 1ns/100ps

module bit_select_seq
    import requant_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  i_en,       // lane enable
    input  logic                  i_valid,    // row valid
    input  logic [IN_WIDTH-1:0]   i_data,     // 32-bit partial sum
    input  logic [CMD_WIDTH-1:0]  i_cmd,      // active lane command

    output logic                  o_valid,
    output logic [OUT_WIDTH-1:0]  o_data
);

    logic                    accept;         // row taken this cycle
    logic                    mode_shift;     // command asks for shifted mode
    logic [SHIFT_WIDTH-1:0]  shift_amt;
    logic [SHIFT_WIDTH:0]    sel_base;       // start bit, one wider so 15+1 fits
    logic [OUT_WIDTH-1:0]    shifted_sel;
    logic [OUT_WIDTH-1:0]    bypass_sel;

    logic [OUT_WIDTH-1:0]    bypass_q;
    logic [OUT_WIDTH-1:0]    shifted_q;
    logic                    mode_q;         // mode that goes with the registered row
    logic                    valid_q;

    assign accept     = i_en & i_valid;
    assign mode_shift = i_cmd[CMD_MODE_BIT];
    assign shift_amt  = i_cmd[SHIFT_WIDTH-1:0];

    // window of OUT_WIDTH bits starting at shift+1
    // highest start is 16, so the window never runs past bit 31
    always_comb
    begin
        sel_base    = {1'b0, shift_amt} + {{SHIFT_WIDTH{1'b0}}, 1'b1};
        shifted_sel = i_data[sel_base +: OUT_WIDTH];
    end

    assign bypass_sel = i_data[OUT_WIDTH-1:0];  // low half unchanged

    // bypass path
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bypass_q <= '0;
        end
        else if (accept && !mode_shift)
        begin
            bypass_q <= bypass_sel;
        end
        else
        begin
            bypass_q <= '0;                     // idle or shifted row
        end
    end

    // shifted path
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shifted_q <= '0;
        end
        else if (accept && mode_shift)
        begin
            shifted_q <= shifted_sel;
        end
        else
        begin
            shifted_q <= '0;                    // idle or bypass row
        end
    end

    // mode and valid travel with the data
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mode_q  <= 1'b0;
            valid_q <= 1'b0;
        end
        else if (accept)
        begin
            mode_q  <= mode_shift;
            valid_q <= 1'b1;
        end
        else
        begin
            mode_q  <= 1'b0;
            valid_q <= 1'b0;
        end
    end

    // registered mode picks the path, so a later commit cannot touch this row
    assign o_data  = mode_q ? shifted_q : bypass_q;
    assign o_valid = valid_q;

endmodule

/* hdl/cmd_regfile.sv */
`timescale 1ns/100ps

module cmd_regfile
    import requant_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,

    // host config port with four-phase req/ack
    input  logic                            i_cfg_req,
    input  logic [LANE_IDX_WIDTH-1:0]       i_cfg_lane,
    input  logic [CMD_WIDTH-1:0]            i_cfg_cmd,
    input  logic                            i_cfg_commit,   // copy shadow to active
    output logic                            o_cfg_ack,

    // active commands with lane k at bits k*CMD_WIDTH upward
    output logic [NUM_LANES*CMD_WIDTH-1:0]  o_lane_cmd
);

    typedef enum logic
    {
        ST_IDLE = 1'b0,                     // waiting for req
        ST_ACK  = 1'b1                      // ack high until req drops
    } hs_state_t;

    hs_state_t               state_q;
    hs_state_t               state_d;

    logic                    cfg_take;      // one pulse per transfer
    logic                    shadow_wr;
    logic                    commit;

    logic [CMD_WIDTH-1:0]    shadow_q [NUM_LANES];
    logic [CMD_WIDTH-1:0]    active_q [NUM_LANES];

    // a request is taken only while ack is still low
    assign cfg_take  = i_cfg_req && (state_q == ST_IDLE);
    assign shadow_wr = cfg_take && !i_cfg_commit;
    assign commit    = cfg_take &&  i_cfg_commit;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (i_cfg_req)
                begin
                    state_d = ST_ACK;
                end
            end
            ST_ACK:
            begin
                if (!i_cfg_req)
                begin
                    state_d = ST_IDLE;      // host released req
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ST_IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    assign o_cfg_ack = (state_q == ST_ACK);

    // shadow bank written one lane per transfer
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_LANES; i++)
            begin
                shadow_q[i] <= '0;          // bypass after reset
            end
        end
        else if (shadow_wr)
        begin
            shadow_q[i_cfg_lane] <= i_cfg_cmd;
        end
    end

    // only a commit touches the active bank
    // takes effect on the same edge that raises ack
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_LANES; i++)
            begin
                active_q[i] <= '0;
            end
        end
        else if (commit)
        begin
            for (int i = 0; i < NUM_LANES; i++)
            begin
                active_q[i] <= shadow_q[i];
            end
        end
    end

    // pack for the lanes
    // a commit is forwarded so the row on the ack edge already sees it
    always_comb
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            o_lane_cmd[i*CMD_WIDTH +: CMD_WIDTH] = commit ? shadow_q[i] : active_q[i];
        end
    end

endmodule

/* hdl/requant_pkg.sv */
package requant_pkg;

    // data path widths
    localparam int IN_WIDTH       = 32;             // one partial sum from the reduction net
    localparam int OUT_WIDTH      = IN_WIDTH / 2;   // requantized result, half of the input

    // lane organisation
    localparam int NUM_LANES      = 4;              // parallel lanes per row
    localparam int LANE_IDX_WIDTH = 2;              // lane index on the config port

    // lane command layout
    //   [CMD_MODE_BIT]      1 = shifted, 0 = bypass
    //   [SHIFT_WIDTH-1:0]   shift s, result starts at bit s+1
    localparam int SHIFT_WIDTH    = 4;              // shift field, 0..15
    localparam int CMD_WIDTH      = SHIFT_WIDTH + 1;
    localparam int CMD_MODE_BIT   = 4;              // msb of the command

endpackage

/* hdl/requant_top.sv */
`timescale 1ns/100ps

module requant_top
    import requant_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_n,

    // row from the reduction network
    input  logic                            i_en,
    input  logic                            i_valid,
    input  logic [NUM_LANES*IN_WIDTH-1:0]   i_data,     // lane k at bits 32k upward

    // row to the output buffer, no back-pressure
    output logic                            o_valid,
    output logic [NUM_LANES*OUT_WIDTH-1:0]  o_data,     // lane k at bits 16k upward

    // host config port
    input  logic                            i_cfg_req,
    input  logic [LANE_IDX_WIDTH-1:0]       i_cfg_lane,
    input  logic [CMD_WIDTH-1:0]            i_cfg_cmd,
    input  logic                            i_cfg_commit,
    output logic                            o_cfg_ack
);

    logic [NUM_LANES*CMD_WIDTH-1:0]  lane_cmd;      // active commands, packed
    logic [NUM_LANES-1:0]            lane_valid;    // identical across lanes

    cmd_regfile u_cmd_regfile
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cfg_req    (i_cfg_req),
        .i_cfg_lane   (i_cfg_lane),
        .i_cfg_cmd    (i_cfg_cmd),
        .i_cfg_commit (i_cfg_commit),
        .o_cfg_ack    (o_cfg_ack),
        .o_lane_cmd   (lane_cmd)
    );

    // one selector per lane, all share valid and enable
    genvar k;
    generate
        for (k = 0; k < NUM_LANES; k++)
        begin : g_lane
            bit_select_seq u_bit_select
            (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_en    (i_en),
                .i_valid (i_valid),
                .i_data  (i_data[k*IN_WIDTH +: IN_WIDTH]),
                .i_cmd   (lane_cmd[k*CMD_WIDTH +: CMD_WIDTH]),
                .o_valid (lane_valid[k]),
                .o_data  (o_data[k*OUT_WIDTH +: OUT_WIDTH])
            );
        end
    endgenerate

    assign o_valid = lane_valid[0];     // lane 0 speaks for the row

endmodule

/* run.sh */
#!/bin/sh
# build the requantizer testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f flist.f --top-module requant_tb -o requant_sim \
    && ./obj_dir/requant_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
    && { cat sim.log; echo "PASS"; exit 0; } \
    || { cat sim.log; echo "FAIL"; exit 1; }
